/* dv/pc_dec_checker.sv */
`default_nettype none

`include "pc_dec_consts.svh"

module pc_dec_checker (
  input  logic                  iclk,
  input  logic                  ireset,
  input  logic                  rdy,
  input  logic                  busy,
  input  pc_dec_pkg::out_word_t out,
  input  logic                  out_valid,
  input  logic                  out_ready,
  output int                    mismatch_cnt,
  output int                    other_cnt,
  output int                    frames_done
);
  timeunit 1ns;
  timeprecision 100ps;

  // Expected frames in input order, filled from the stim file
  logic [`PC_TAG_W-1:0]         exp_tag  [$];
  int                           exp_dlen [$];
  logic [`PC_N*`PC_LLR_W-1:0]   exp_llrs [$];  // Stream index 0 in the top nibble
  logic [`PC_N-1:0]             exp_map  [$];  // Bit j set when position j frozen
  int                           word_idx;      // Word inside the current output frame
  int                           rdy_low_cnt;   // rdy low longer than the end of frame gap
  logic                         rdy_q;         // rdy on the previous edge
  logic                         hold_q;        // Output stalled on the previous edge
  pc_dec_pkg::out_word_t        out_q;         // Word offered on the previous edge

  // Input stream index that lands on output address j
  function automatic int bit_reverse(input int j);
    int r;
    r = 0;
    for (int i = 0; i < `PC_NLOG2; i++) begin
      r = (r << 1) | ((j >> i) & 1);
    end
    return r;
  endfunction

  // Channel LLR into decoder sign, clipped to the largest positive code
  function automatic int negate_llr(input logic [`PC_LLR_W-1:0] x);
    int v;
    v = -int'($signed(x));
    if (v > (1 << (`PC_LLR_W-1)) - 1) begin
      v = (1 << (`PC_LLR_W-1)) - 1;
    end
    return v;
  endfunction

  task automatic add_frame(input logic [`PC_TAG_W-1:0] t, input int d,
                           input logic [`PC_N*`PC_LLR_W-1:0] l,
                           input logic [`PC_N-1:0] m);
    exp_tag.push_back(t);
    exp_dlen.push_back(d);
    exp_llrs.push_back(l);
    exp_map.push_back(m);
  endtask

  task automatic report_mismatch(input string name, input int exp_v, input int act_v);
    $display("Fail %s frame %0d word %0d: expected %0d, actual %0d",
             name, frames_done, word_idx, exp_v, act_v);
    mismatch_cnt++;
  endtask

  // End of run: every frame out, and input flow control exercised
  task automatic final_check(output int errs);
    errs = 0;
    if (exp_tag.size() != frames_done) begin
      $display("Error: %0d frames expected but %0d came out", exp_tag.size(), frames_done);
      errs++;
    end
    if (rdy_low_cnt == 0) begin
      $display("Error: input rdy was never held low by full banks");
      errs++;
    end
  endtask

  //-------------------------------------------------------------------------
  // Output monitor, sampled on the rising edge
  //-------------------------------------------------------------------------

  always @(posedge iclk) begin
    logic [`PC_N*`PC_LLR_W-1:0] llrs;
    int                         k;
    if (ireset) begin
      mismatch_cnt = 0;
      other_cnt    = 0;
      frames_done  = 0;
      word_idx     = 0;
      rdy_low_cnt  = 0;
      rdy_q        = 1'b1;
      hold_q       = 1'b0;
      out_q        = '0;
    end else begin
      if (!rdy && !rdy_q) rdy_low_cnt++;  // Both banks full
      rdy_q = rdy;
      if (hold_q && (!out_valid || out !== out_q)) begin
        $display("Error: output word dropped or changed while stalled");
        other_cnt++;
      end
      hold_q = out_valid && !out_ready;
      out_q  = out;
      if (out_valid && !busy) begin
        $display("Error: busy low while output data is pending");
        other_cnt++;
      end
      if (out_valid && out_ready) begin  // One word transferred
        if (frames_done >= exp_tag.size()) begin
          $display("Error: output word with no frame left to expect");
          other_cnt++;
        end else begin
          llrs = exp_llrs[frames_done];
          k    = bit_reverse(word_idx);
          if (out.sop !== (word_idx == 0)) report_mismatch("sop", word_idx == 0, out.sop);
          if (out.eop !== (word_idx == `PC_N-1)) begin
            report_mismatch("eop", word_idx == `PC_N-1, out.eop);
          end
          if (out.tag !== exp_tag[frames_done]) begin
            report_mismatch("tag", exp_tag[frames_done], out.tag);
          end
          if (int'(out.dlen) != exp_dlen[frames_done]) begin
            report_mismatch("dlen", exp_dlen[frames_done], out.dlen);
          end
          if (int'(out.llr) != negate_llr(llrs[`PC_N*`PC_LLR_W-1-`PC_LLR_W*k -: `PC_LLR_W])) begin
            report_mismatch("llr", negate_llr(llrs[`PC_N*`PC_LLR_W-1-`PC_LLR_W*k -: `PC_LLR_W]),
                            out.llr);
          end
          if (out.frzb !== exp_map[frames_done][word_idx]) begin
            report_mismatch("frozen", exp_map[frames_done][word_idx], out.frzb);
          end
        end
        if (word_idx == `PC_N-1) begin  // Frame complete
          word_idx = 0;
          frames_done++;
        end else begin
          word_idx++;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* dv/pc_dec_stim.txt */
# tag(hex) dlen(dec) llrs(32 hex digits, 4-bit two's complement, stream index 0 first)
# frozen_map(hex, bit j set when output position j is frozen)
1 0 0123456789abcdef0123456789abcdef ffffffff
2 32 88888888888888888888888888888888 00000000
3 16 fedcba9876543210fedcba9876543210 fee8e880
4 8 13579bdf02468ace8ace02469bdf1357 fffefec0
5 1 7f807f807f807f807f807f807f807f80 fffffffe
6 31 00000000111111112222222233333333 80000000
7 24 c3a58e1f6b2d94070f1e2d3c4b5a6978 f8c08000
8 12 9876543210fedcba9876543210fedcba fffcf880
9 20 5a5a5a5aa5a5a5a5deadbeefcafef00d fee0c000
a 16 8765432187654321abcdef12abcdef12 fee8e880

/* dv/tb_pc_dec_front.sv */
`default_nettype none

`include "pc_dec_consts.svh"

module tb_pc_dec_front;
  timeunit 1ns;
  timeprecision 100ps;

  logic                  iclk;
  logic                  ireset;
  pc_dec_pkg::dlen_t     dlen;
  logic                  sop;
  logic                  val;
  logic                  eop;
  pc_dec_pkg::llr_t      llr;
  pc_dec_pkg::tag_t      tag;
  logic                  rdy;
  logic                  busy;
  pc_dec_pkg::out_word_t out;
  logic                  out_valid;
  logic                  out_ready;

  int mismatch_cnt;
  int other_cnt;
  int frames_done;
  int tb_err_cnt = 0;
  int n_frames = 0;
  int cycle_cnt = 0;
  int cycle_limit = 0;                             // Zero until frames are known

  logic [`PC_TAG_W-1:0]       f_tag  [$];          // Frames as read from file
  int                         f_dlen [$];
  logic [`PC_N*`PC_LLR_W-1:0] f_llrs [$];

  pc_dec_front i_dut (
    .iclk      (iclk),
    .ireset    (ireset),
    .dlen      (dlen),
    .sop       (sop),
    .val       (val),
    .eop       (eop),
    .llr       (llr),
    .tag       (tag),
    .rdy       (rdy),
    .busy      (busy),
    .out       (out),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  pc_dec_checker i_checker (
    .iclk         (iclk),
    .ireset       (ireset),
    .rdy          (rdy),
    .busy         (busy),
    .out          (out),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .mismatch_cnt (mismatch_cnt),
    .other_cnt    (other_cnt),
    .frames_done  (frames_done)
  );

  initial begin
    iclk = 1'b0;
    forever #4 iclk = ~iclk;  // 8 ns period
  end

  // Parse frames and hand the expectations to the checker
  task automatic read_stim();
    int                         fd;
    int                         n;
    string                      line;
    logic [`PC_TAG_W-1:0]       t;
    int                         d;
    logic [`PC_N*`PC_LLR_W-1:0] l;
    logic [`PC_N-1:0]           m;
    fd = $fopen("dv/pc_dec_stim.txt", "r");
    if (fd == 0) begin
      $display("Error: cannot open dv/pc_dec_stim.txt");
      tb_err_cnt++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 1 && line.getc(0) != "#") begin  // Skip blank and comment lines
          if ($sscanf(line, "%h %d %h %h", t, d, l, m) == 4) begin
            f_tag.push_back(t);
            f_dlen.push_back(d);
            f_llrs.push_back(l);
            i_checker.add_frame(t, d, l, m);
          end else begin
            $display("Error: malformed line in stimulus file: %s", line);
            tb_err_cnt++;
          end
        end
      end
      $fclose(fd);
    end
    n_frames = f_tag.size();
  endtask

  // One input word, held until taken; tag and dlen carry junk off sop
  task automatic send_word(input int k, input logic [`PC_TAG_W-1:0] t, input int d,
                           input logic [`PC_LLR_W-1:0] x);
    logic taken;
    if ($urandom % 8 == 0) begin  // Occasional idle gap
      val <= 1'b0;
      repeat ($urandom % 3 + 1) @(posedge iclk);
    end
    val  <= 1'b1;
    sop  <= (k == 0);
    eop  <= (k == `PC_N-1);
    llr  <= x;
    tag  <= (k == 0) ? t : pc_dec_pkg::tag_t'($urandom);
    dlen <= (k == 0) ? pc_dec_pkg::dlen_t'(d) : pc_dec_pkg::dlen_t'($urandom);
    do begin
      @(negedge iclk);
      taken = rdy;  // Stable between edges
      @(posedge iclk);
    end while (!taken);
  endtask

  function automatic void print_counts(input int more);
    $display("errors: %0d total (%0d mismatches, %0d other, %0d testbench)",
             mismatch_cnt + other_cnt + tb_err_cnt + more, mismatch_cnt, other_cnt,
             tb_err_cnt + more);
  endfunction

  //-------------------------------------------------------------------------
  // Main sequence
  //-------------------------------------------------------------------------

  initial begin
    logic [`PC_N*`PC_LLR_W-1:0] l;
    int                         extra;
    void'($urandom(99));
    ireset = 1'b1;
    val    = 1'b0;
    sop    = 1'b0;
    eop    = 1'b0;
    llr    = '0;
    tag    = '0;
    dlen   = '0;
    read_stim();
    if (n_frames == 0) begin
      $display("Error: no frames in stimulus file");
      tb_err_cnt++;
    end
    cycle_limit = n_frames * `PC_N * 4 + 500;
    repeat (4) @(posedge iclk);
    ireset <= 1'b0;
    for (int f = 0; f < n_frames; f++) begin
      l = f_llrs[f];
      for (int k = 0; k < `PC_N; k++) begin
        send_word(k, f_tag[f], f_dlen[f], l[`PC_N*`PC_LLR_W-1-`PC_LLR_W*k -: `PC_LLR_W]);
      end
    end
    val <= 1'b0;
    sop <= 1'b0;
    eop <= 1'b0;
    while (frames_done < n_frames) @(posedge iclk);
    repeat (8) @(posedge iclk);  // Catch stray words after the last frame
    i_checker.final_check(extra);
    tb_err_cnt += extra;
    print_counts(0);
    if (mismatch_cnt + other_cnt + tb_err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Output ready, random with long stall stretches
  initial begin
    out_ready = 1'b0;
    @(negedge ireset);
    forever begin
      repeat (150) begin
        @(posedge iclk);
        out_ready <= ($urandom % 4 != 0);
      end
      repeat ($urandom % 100 + 50) begin
        @(posedge iclk);
        out_ready <= 1'b0;
      end
    end
  end

  // Run limit, scaled by frame count
  always @(posedge iclk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Error: timeout after %0d cycles, %0d of %0d frames came out",
               cycle_cnt, frames_done, n_frames);
      print_counts(1);
      $display("sim failed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the polar decoder front end testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module tb_pc_dec_front \
  && ./obj_dir/Vtb_pc_dec_front > sim.log 2>&1 \
  || echo "build or simulation did not complete"

cat sim.log 2>/dev/null
grep -qx "sim passed" sim.log && echo "result: pass" && exit 0 \
  || { echo "result: fail"; exit 1; }

/* sources.f */
+incdir+src
src/pc_dec_pkg.sv
src/pc_dec_source.sv
src/pc_dec_frame_buffer.sv
src/pc_dec_sink.sv
src/pc_dec_front.sv
dv/pc_dec_checker.sv
dv/tb_pc_dec_front.sv

/* src/pc_dec_consts.svh */
`ifndef PC_DEC_CONSTS_SVH
`define PC_DEC_CONSTS_SVH

//---------------------------------------------------------------------------
// Polar decoder front end sizes
//---------------------------------------------------------------------------

// Frame length, one codeword
`define PC_N      32

// Bit address width, log2 of frame length
`define PC_NLOG2  5

`define PC_LLR_W  4   // Channel LLR width, two's complement
`define PC_TAG_W  4   // Frame tag width

`endif

/* src/pc_dec_frame_buffer.sv */
`default_nettype none

`include "pc_dec_consts.svh"

module pc_dec_frame_buffer (
  input  logic                  iclk,
  input  logic                  ireset,
  // Write side
  input  pc_dec_pkg::wr_word_t  wr,
  output logic                  full_any,
  output logic                  empty_all,
  // Read side
  input  pc_dec_pkg::bit_addr_t rd_addr,
  input  logic                  rd_en,
  input  logic                  rd_release,
  output logic                  rd_avail,
  output pc_dec_pkg::llr_t      rd_llr,
  output logic                  rd_frzb,
  output pc_dec_pkg::tag_t      rd_tag,
  output pc_dec_pkg::dlen_t     rd_dlen
);

  //-------------------------------------------------------------------------
  // Storage, two banks
  //-------------------------------------------------------------------------

  pc_dec_pkg::llr_t  llr_mem  [2][`PC_N];  // LLRs, bit reversed order
  logic              frzb_mem [2][`PC_N];  // Frozen map
  pc_dec_pkg::tag_t  tag_mem  [2];
  pc_dec_pkg::dlen_t dlen_mem [2];

  logic       wbank;      // Bank being written
  logic       rbank;      // Bank being read
  logic [1:0] bank_full;  // Per bank, frame complete

  //-------------------------------------------------------------------------
  // Bank pointers and full state
  //-------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wbank     <= 1'b0;
      rbank     <= 1'b0;
      bank_full <= '0;
    end else begin
      if (wr.write && wr.full) begin
        bank_full[wbank] <= 1'b1;  // Visible the cycle after the last write
        wbank            <= ~wbank;
      end
      if (rd_release) begin
        bank_full[rbank] <= 1'b0;
        rbank            <= ~rbank;
      end
    end
  end

  // Write port
  always_ff @(posedge iclk) begin
    if (wr.write) begin
      llr_mem[wbank][wr.llr_addr]   <= wr.llr;
      frzb_mem[wbank][wr.frzb_addr] <= wr.frzb;
      tag_mem[wbank]                <= wr.tag;   // Same on every word
      dlen_mem[wbank]               <= wr.dlen;
    end
  end

  // Read port, one cycle latency
  always_ff @(posedge iclk) begin
    if (rd_en) begin
      rd_llr  <= llr_mem[rbank][rd_addr];
      rd_frzb <= frzb_mem[rbank][rd_addr];
    end
  end

  assign rd_avail  = bank_full[rbank];
  assign rd_tag    = tag_mem[rbank];   // Stable until release
  assign rd_dlen   = dlen_mem[rbank];
  assign full_any  = &bank_full;       // No free bank
  assign empty_all = ~|bank_full;

  //-------------------------------------------------------------------------
  // Checks on the source and sink handshakes
  //-------------------------------------------------------------------------

  a_no_overwrite : assert property (@(posedge iclk) disable iff (ireset)
    wr.write |-> !bank_full[wbank])
    else $error("write into full bank %0d", wbank);

  a_release_full : assert property (@(posedge iclk) disable iff (ireset)
    rd_release |-> bank_full[rbank])
    else $error("release of empty bank %0d", rbank);

endmodule

`default_nettype wire

/* src/pc_dec_front.sv */
`default_nettype none

module pc_dec_front (
  input  logic                  iclk,
  input  logic                  ireset,
  // Frame input
  input  pc_dec_pkg::dlen_t     dlen,
  input  logic                  sop,
  input  logic                  val,
  input  logic                  eop,
  input  pc_dec_pkg::llr_t      llr,
  input  pc_dec_pkg::tag_t      tag,
  output logic                  rdy,
  output logic                  busy,
  // Frame output
  output pc_dec_pkg::out_word_t out,
  output logic                  out_valid,
  input  logic                  out_ready
);

  //-------------------------------------------------------------------------
  // Internal links
  //-------------------------------------------------------------------------

  pc_dec_pkg::wr_word_t  wr;          // Source to buffer
  logic                  full_any;
  logic                  empty_all;
  logic                  rd_avail;    // Buffer to sink
  pc_dec_pkg::llr_t      rd_llr;
  logic                  rd_frzb;
  pc_dec_pkg::tag_t      rd_tag;
  pc_dec_pkg::dlen_t     rd_dlen;
  pc_dec_pkg::bit_addr_t rd_addr;     // Sink to buffer
  logic                  rd_en;
  logic                  rd_release;

  // Input reorder and frozen map
  pc_dec_source i_source (
    .iclk      (iclk),
    .ireset    (ireset),
    .dlen      (dlen),
    .sop       (sop),
    .val       (val),
    .eop       (eop),
    .llr       (llr),
    .tag       (tag),
    .rdy       (rdy),
    .busy      (busy),
    .full_any  (full_any),
    .empty_all (empty_all),
    .wr        (wr)
  );

  // Ping pong storage
  pc_dec_frame_buffer i_buffer (
    .iclk       (iclk),
    .ireset     (ireset),
    .wr         (wr),
    .full_any   (full_any),
    .empty_all  (empty_all),
    .rd_addr    (rd_addr),
    .rd_en      (rd_en),
    .rd_release (rd_release),
    .rd_avail   (rd_avail),
    .rd_llr     (rd_llr),
    .rd_frzb    (rd_frzb),
    .rd_tag     (rd_tag),
    .rd_dlen    (rd_dlen)
  );

  // Natural order readout
  pc_dec_sink i_sink (
    .iclk       (iclk),
    .ireset     (ireset),
    .rd_avail   (rd_avail),
    .rd_llr     (rd_llr),
    .rd_frzb    (rd_frzb),
    .rd_tag     (rd_tag),
    .rd_dlen    (rd_dlen),
    .rd_addr    (rd_addr),
    .rd_en      (rd_en),
    .rd_release (rd_release),
    .out        (out),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
  );

endmodule

`default_nettype wire

/* src/pc_dec_pkg.sv */
`default_nettype none

`include "pc_dec_consts.svh"

package pc_dec_pkg;

  //-------------------------------------------------------------------------
  // Scalar types
  //-------------------------------------------------------------------------

  typedef logic signed [`PC_LLR_W-1:0] llr_t;      // Signed soft bit
  typedef logic        [`PC_TAG_W-1:0] tag_t;      // User tag
  typedef logic        [`PC_NLOG2-1:0] bit_addr_t; // Position inside frame
  typedef logic        [`PC_NLOG2:0]   dlen_t;     // 0..N, one extra bit

  // One write into the frame buffer
  typedef struct packed {
    logic      write;     // Strobe
    logic      full;      // Last word of the frame
    bit_addr_t llr_addr;  // Bit reversed stream index
    bit_addr_t frzb_addr; // Position from reliability table
    llr_t      llr;
    logic      frzb;      // Frozen flag
    tag_t      tag;
    dlen_t     dlen;
  } wr_word_t;

  // One output word, natural order
  typedef struct packed {
    logic  sop;
    logic  eop;
    llr_t  llr;
    logic  frzb;
    tag_t  tag;
    dlen_t dlen;
  } out_word_t;

  // Reliability order for N = 32, least reliable position first
  localparam bit_addr_t rel_tab [`PC_N] = '{
    5'd0,  5'd1,  5'd2,  5'd4,  5'd8,  5'd16, 5'd3,  5'd5,
    5'd9,  5'd6,  5'd17, 5'd10, 5'd18, 5'd12, 5'd20, 5'd24,
    5'd7,  5'd11, 5'd19, 5'd13, 5'd14, 5'd21, 5'd26, 5'd25,
    5'd22, 5'd28, 5'd15, 5'd23, 5'd27, 5'd29, 5'd30, 5'd31
  };

endpackage

`default_nettype wire

/* src/pc_dec_sink.sv */
`default_nettype none

`include "pc_dec_consts.svh"

module pc_dec_sink (
  input  logic                   iclk,
  input  logic                   ireset,
  // Buffer read side
  input  logic                   rd_avail,
  input  pc_dec_pkg::llr_t       rd_llr,
  input  logic                   rd_frzb,
  input  pc_dec_pkg::tag_t       rd_tag,
  input  pc_dec_pkg::dlen_t      rd_dlen,
  output pc_dec_pkg::bit_addr_t  rd_addr,
  output logic                   rd_en,
  output logic                   rd_release,
  // Output stream
  output pc_dec_pkg::out_word_t  out,
  output logic                   out_valid,
  input  logic                   out_ready
);

  logic                  s1_valid;  // Read data waiting in buffer register
  pc_dec_pkg::bit_addr_t s1_addr;   // Its address, for sop and eop
  logic                  rd_done;   // All 32 reads issued for this bank
  logic                  move;      // Stage 1 into output register

  assign move       = s1_valid & (~out_valid | out_ready);
  assign rd_en      = rd_avail & ~rd_done & (~s1_valid | move);
  assign rd_release = out_valid & out_ready & out.eop;  // Last word taken

  //-------------------------------------------------------------------------
  // Pipeline control
  //-------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      rd_addr   <= '0;
      rd_done   <= 1'b0;
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      if (rd_en) begin
        rd_addr <= rd_addr + 1'b1;  // Wraps to 0 for next frame
        if (rd_addr == `PC_N-1) begin
          rd_done <= 1'b1;
        end
      end
      if (rd_release) begin
        rd_done <= 1'b0;  // Next bank may start
      end
      if (rd_en) begin
        s1_valid <= 1'b1;
      end else if (move) begin
        s1_valid <= 1'b0;
      end
      if (move) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  // Address stage and output register
  always_ff @(posedge iclk) begin
    if (rd_en) begin
      s1_addr <= rd_addr;
    end
    if (move) begin
      out.sop  <= (s1_addr == '0);
      out.eop  <= (s1_addr == `PC_N-1);
      out.llr  <= rd_llr;
      out.frzb <= rd_frzb;
      out.tag  <= rd_tag;
      out.dlen <= rd_dlen;
    end
  end

  // Bank under read stays full until this side releases it
  a_bank_held : assert property (@(posedge iclk) disable iff (ireset)
    (rd_addr != '0 || rd_done) |-> rd_avail)
    else $error("read bank emptied before release");

endmodule

`default_nettype wire

/* src/pc_dec_source.sv */
`default_nettype none

`include "pc_dec_consts.svh"

module pc_dec_source (
  input  logic                  iclk,
  input  logic                  ireset,
  // Frame input
  input  pc_dec_pkg::dlen_t     dlen,
  input  logic                  sop,
  input  logic                  val,
  input  logic                  eop,
  input  pc_dec_pkg::llr_t      llr,
  input  pc_dec_pkg::tag_t      tag,
  output logic                  rdy,
  output logic                  busy,
  // Buffer state
  input  logic                  full_any,
  input  logic                  empty_all,
  // Buffer write port
  output pc_dec_pkg::wr_word_t  wr
);

  // Reverse the bit order of an address
  function automatic pc_dec_pkg::bit_addr_t bit_rev(input pc_dec_pkg::bit_addr_t a);
    pc_dec_pkg::bit_addr_t r;
    for (int i = 0; i < `PC_NLOG2; i++) begin
      r[i] = a[`PC_NLOG2-1-i];
    end
    return r;
  endfunction

  logic                  acc;       // Word taken this cycle
  logic                  in_frame;  // Between sop and eop
  pc_dec_pkg::bit_addr_t k_la;      // Look ahead stream index
  pc_dec_pkg::bit_addr_t k_cur;     // Index of the word on the bus
  pc_dec_pkg::dlen_t     dlen_q;
  pc_dec_pkg::dlen_t     dlen_cur;
  pc_dec_pkg::tag_t      tag_q;
  pc_dec_pkg::tag_t      tag_cur;
  logic                  write_q;
  logic                  full_q;
  pc_dec_pkg::bit_addr_t llr_addr_q;
  pc_dec_pkg::bit_addr_t frzb_addr_q;
  pc_dec_pkg::llr_t      llr_q;
  logic                  frzb_q;

  assign acc      = val & rdy;
  assign k_cur    = sop ? '0 : k_la;      // Index restarts on sop
  assign dlen_cur = sop ? dlen : dlen_q;  // Same cycle value on sop
  assign tag_cur  = sop ? tag : tag_q;

  //-------------------------------------------------------------------------
  // Control state
  //-------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      write_q  <= 1'b0;
      full_q   <= 1'b0;
      in_frame <= 1'b0;
      k_la     <= '0;
    end else begin
      write_q <= acc;
      full_q  <= acc & eop;  // Frame index 31
      if (acc) begin
        k_la     <= k_cur + 1'b1;
        in_frame <= ~eop;
      end
    end
  end

  //-------------------------------------------------------------------------
  // Write payload, one cycle after acceptance
  //-------------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (acc) begin
      if (llr == {1'b1, {(`PC_LLR_W-1){1'b0}}}) begin  // Most negative code
        llr_q <= {1'b0, {(`PC_LLR_W-1){1'b1}}};          // Saturate to max
      end else begin
        llr_q <= -llr;                                   // Decoder sign convention
      end
      llr_addr_q  <= bit_rev(k_cur);
      frzb_addr_q <= pc_dec_pkg::rel_tab[k_cur];
      frzb_q      <= ({1'b0, k_cur} >= dlen_cur);        // Beyond info length
      dlen_q      <= dlen_cur;
      tag_q       <= tag_cur;
    end
  end

  always_comb begin
    wr.write     = write_q;
    wr.full      = full_q;
    wr.llr_addr  = llr_addr_q;
    wr.frzb_addr = frzb_addr_q;
    wr.llr       = llr_q;
    wr.frzb      = frzb_q;
    wr.tag       = tag_q;
    wr.dlen      = dlen_q;
  end

  assign rdy  = ~full_q & ~full_any;                // Hold off on last word or no bank
  assign busy = in_frame | write_q | ~empty_all;    // Anything still in flight

  // A frame always ends on its 32nd word
  a_frame_len : assert property (@(posedge iclk) disable iff (ireset)
    acc && eop |-> k_cur == `PC_N-1)
    else $error("eop accepted at stream index %0d", k_cur);

endmodule

`default_nettype wire
